// ==== Makefile ====
# Verilator build for the SDRAM slot multiplexer testbench
# override any variable on the command line, e.g. make run OBJ_DIR=build

VERILATOR ?= verilator
TOP       ?= sdram_mux_tb
OBJ_DIR   ?= obj_dir
FILELIST  ?= list.f
VFLAGS    ?= --binary --timing --assert
EXTRA     ?=

BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(wildcard hdl/*.sv hdl/*.svh testbench/*.sv)
	$(VERILATOR) $(VFLAGS) $(EXTRA) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

# a $fatal in the testbench gives a non-zero exit status
run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)

// ==== hdl/offset_regs.sv ====
// host-visible base offsets of the two slots
// a write updates one offset and flushes both caches a cycle later
`timescale 1ns/1ps
`include "sdram_mux_consts.svh"

module offset_regs (
    input  logic                        clk,
    input  logic                        rst,
    input  sdram_mux_pkg::cfg_wr_t      cfg,
    input  logic                        rd_sel,     // 0 slot 0, 1 slot 1
    output sdram_mux_pkg::sdram_addr_t  cfg_rdata,
    output sdram_mux_pkg::offsets_t     offsets,
    output logic                        flush
);
    sdram_mux_pkg::sdram_addr_t off0, off1;

    always_ff @(posedge clk) begin
        if (rst) begin
            off0  <= `SLOT0_OFFSET_RST;
            off1  <= `SLOT1_OFFSET_RST;
            flush <= 1'b0;
        end else begin
            flush <= cfg.we;                 // one pulse per write
            if (cfg.we) begin
                if (cfg.sel)
                    off1 <= cfg.offset;
                else
                    off0 <= cfg.offset;
            end
        end
    end

    assign offsets.slot0 = off0;
    assign offsets.slot1 = off1;

    // readback straight from the registers
    always_comb begin
        if (rd_sel)
            cfg_rdata = off1;
        else
            cfg_rdata = off0;
    end

endmodule

// ==== hdl/sdram_mux_consts.svh ====
// widths and reset offsets shared by the SDRAM slot multiplexer
// include wherever a slot or SDRAM address width is needed
`ifndef SDRAM_MUX_CONSTS_SVH
`define SDRAM_MUX_CONSTS_SVH

// SDRAM side, counted in 16-bit words
`define SDRAM_AW 22

// slot 0 addresses 16-bit units
`define SLOT0_AW 16

// slot 1 addresses bytes, ROM style
`define SLOT1_AW 17

// payload widths of the two slots
`define SLOT0_DW 16
`define SLOT1_DW 8

// controller read word, two SDRAM words side by side
`define SDRAM_RD_DW 32

// controller write data and byte mask
`define SDRAM_WR_DW 16
`define SDRAM_MASKW 2

// number of client slots
`define SLOT_NUM 2

// base offsets after reset, in SDRAM words
`define SLOT0_OFFSET_RST 22'h000000
`define SLOT1_OFFSET_RST 22'h100000

`endif

// ==== hdl/sdram_mux_pkg.sv ====
// types for the slot requesters, the arbiter and the controller port
// compile before every other design file
`include "sdram_mux_consts.svh"

package sdram_mux_pkg;

    typedef logic [`SDRAM_AW-1:0]    sdram_addr_t;
    typedef logic [`SLOT0_DW-1:0]    slot0_data_t;
    typedef logic [`SLOT1_DW-1:0]    slot1_data_t;
    typedef logic [`SDRAM_RD_DW-1:0] sdram_rd_word_t;
    typedef logic [`SLOT_NUM-1:0]    slot_sel_t;     // one-hot, bit 0 is slot 0

    // levels towards the controller, rd/wr held until ack
    typedef struct packed {
        logic                    rd;
        logic                    wr;
        sdram_addr_t             addr;
        logic [`SDRAM_WR_DW-1:0] wdata;
        logic [`SDRAM_MASKW-1:0] wrmask;  // active low per byte
    } sdram_cmd_t;

    typedef struct packed {
        logic           ack;       // command taken
        logic           data_rdy;  // one-cycle pulse
        sdram_rd_word_t rdata;     // low half is the even word
    } sdram_rsp_t;

    // requester to arbiter
    typedef struct packed {
        logic                    req;
        logic                    rnw;
        sdram_addr_t             addr;
        logic [`SDRAM_WR_DW-1:0] wdata;
        logic [`SDRAM_MASKW-1:0] wrmask;  // already active low
    } slot_fetch_t;

    // host write port of the offset block
    typedef struct packed {
        logic        we;
        logic        sel;     // 0 slot 0, 1 slot 1
        sdram_addr_t offset;
    } cfg_wr_t;

    typedef struct packed {
        sdram_addr_t slot1;
        sdram_addr_t slot0;
    } offsets_t;

endpackage

// ==== hdl/sdram_mux_top.sv ====
// two-slot SDRAM front end: slot 0 read/write 16-bit, slot 1 byte ROM
// hook sdram_cmd/sdram_rsp to the controller and cfg to the host
`timescale 1ns/1ps
`include "sdram_mux_consts.svh"

module sdram_mux_top (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [`SLOT0_AW-1:0]        slot0_addr,
    input  logic                        slot0_cs,
    input  logic                        slot0_wen,
    input  sdram_mux_pkg::slot0_data_t  slot0_din,
    input  logic [1:0]                  slot0_wrmask,
    input  logic [`SLOT1_AW-1:0]        slot1_addr,
    input  logic                        slot1_cs,
    input  sdram_mux_pkg::cfg_wr_t      cfg,
    input  logic                        cfg_rd_sel,
    input  sdram_mux_pkg::sdram_rsp_t   sdram_rsp,
    output sdram_mux_pkg::slot0_data_t  slot0_dout,
    output logic                        slot0_ok,
    output sdram_mux_pkg::slot1_data_t  slot1_dout,
    output logic                        slot1_ok,
    output sdram_mux_pkg::sdram_addr_t  cfg_rdata,
    output sdram_mux_pkg::sdram_cmd_t   sdram_cmd
);
    sdram_mux_pkg::slot_fetch_t     fetch0, fetch1;
    sdram_mux_pkg::slot_sel_t       take, fill;
    sdram_mux_pkg::sdram_rd_word_t  rd_word;
    sdram_mux_pkg::offsets_t        offsets;
    logic                           flush;

    slot_req #(
        .payload_t (sdram_mux_pkg::slot0_data_t),
        .AW        (`SLOT0_AW),
        .can_write (1'b1)
    ) i_slot0 (
        .clk     (clk),
        .rst     (rst),
        .addr    (slot0_addr),
        .cs      (slot0_cs),
        .wen     (slot0_wen),
        .din     (slot0_din),
        .wrmask  (slot0_wrmask),
        .offset  (offsets.slot0),
        .flush   (flush),
        .take    (take[0]),
        .fill    (fill[0]),
        .rd_word (rd_word),
        .fetch   (fetch0),
        .dout    (slot0_dout),
        .ok      (slot0_ok)
    );

    slot_req #(
        .payload_t (sdram_mux_pkg::slot1_data_t),
        .AW        (`SLOT1_AW),
        .can_write (1'b0)
    ) i_slot1 (
        .clk     (clk),
        .rst     (rst),
        .addr    (slot1_addr),
        .cs      (slot1_cs),
        .wen     (1'b0),            // read-only port
        .din     ('0),
        .wrmask  (2'b00),
        .offset  (offsets.slot1),
        .flush   (flush),
        .take    (take[1]),
        .fill    (fill[1]),
        .rd_word (rd_word),
        .fetch   (fetch1),
        .dout    (slot1_dout),
        .ok      (slot1_ok)
    );

    sdram_slot_arb i_arb (
        .clk     (clk),
        .rst     (rst),
        .fetch0  (fetch0),
        .fetch1  (fetch1),
        .rsp     (sdram_rsp),
        .take    (take),
        .fill    (fill),
        .rd_word (rd_word),
        .cmd     (sdram_cmd)
    );

    offset_regs i_offsets (
        .clk       (clk),
        .rst       (rst),
        .cfg       (cfg),
        .rd_sel    (cfg_rd_sel),
        .cfg_rdata (cfg_rdata),
        .offsets   (offsets),
        .flush     (flush)
    );

endmodule

// ==== hdl/sdram_slot_arb.sv ====
// fixed-priority arbiter between the two requesters, slot 0 first
// one access in flight, next one taken when idle or at data_rdy
`timescale 1ns/1ps

module sdram_slot_arb (
    input  logic                          clk,
    input  logic                          rst,
    input  sdram_mux_pkg::slot_fetch_t    fetch0,
    input  sdram_mux_pkg::slot_fetch_t    fetch1,
    input  sdram_mux_pkg::sdram_rsp_t     rsp,
    output sdram_mux_pkg::slot_sel_t      take,
    output sdram_mux_pkg::slot_sel_t      fill,
    output sdram_mux_pkg::sdram_rd_word_t rd_word,
    output sdram_mux_pkg::sdram_cmd_t     cmd
);
    sdram_mux_pkg::slot_sel_t    owner, grant;
    sdram_mux_pkg::slot_fetch_t  sel_fetch;
    sdram_mux_pkg::sdram_addr_t  cmd_addr;
    sdram_mux_pkg::slot0_data_t  cmd_wdata;
    logic [1:0]                  cmd_mask;
    logic                        cmd_rd, cmd_wr;
    logic                        wait_ack;   // ack of current access not seen yet
    logic                        done, accept;

    // data_rdy counts only once ack is behind us
    assign done   = rsp.data_rdy && !wait_ack && (owner != '0);
    assign accept = (owner == '0) || done;

    always_comb begin
        if (fetch0.req)
            grant = 2'b01;
        else if (fetch1.req)
            grant = 2'b10;
        else
            grant = 2'b00;
    end

    assign sel_fetch = grant[0] ? fetch0 : fetch1;

    assign take    = accept ? grant : '0;    // drops req in the requester
    assign fill    = done ? owner : '0;
    assign rd_word = rsp.rdata;

    always_ff @(posedge clk) begin
        if (rst) begin
            cmd_rd   <= 1'b0;
            cmd_wr   <= 1'b0;
            owner    <= '0;
            wait_ack <= 1'b0;
        end else begin
            if (wait_ack && rsp.ack) begin
                cmd_rd   <= 1'b0;
                cmd_wr   <= 1'b0;
                wait_ack <= 1'b0;
            end
            if (accept) begin
                owner    <= grant;           // zero when nobody asks
                wait_ack <= |grant;
                cmd_rd   <= (|grant) & sel_fetch.rnw;
                cmd_wr   <= (|grant) & ~sel_fetch.rnw;
            end
        end
    end

    // address and write data held from issue through ack
    always_ff @(posedge clk) begin
        if (accept && (|grant)) begin
            cmd_addr  <= sel_fetch.addr;
            cmd_wdata <= sel_fetch.wdata;
            cmd_mask  <= sel_fetch.wrmask;
        end
    end

    assign cmd.rd     = cmd_rd;
    assign cmd.wr     = cmd_wr;
    assign cmd.addr   = cmd_addr;
    assign cmd.wdata  = cmd_wdata;
    assign cmd.wrmask = cmd_mask;

endmodule

// ==== hdl/slot_req.sv ====
// per-slot requester: adds the base offset, keeps one 32-bit word and
// raises a fetch towards the arbiter on a miss or a write
`timescale 1ns/1ps
`include "sdram_mux_consts.svh"

module slot_req #(
    parameter type payload_t = sdram_mux_pkg::slot0_data_t,
    parameter int  AW        = `SLOT0_AW,
    parameter bit  can_write = 1'b1
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [AW-1:0]               addr,
    input  logic                        cs,
    input  logic                        wen,
    input  payload_t                    din,
    input  logic [1:0]                  wrmask,   // active high per byte
    input  sdram_mux_pkg::sdram_addr_t  offset,
    input  logic                        flush,
    input  logic                        take,
    input  logic                        fill,
    input  sdram_mux_pkg::sdram_rd_word_t rd_word,
    output sdram_mux_pkg::slot_fetch_t  fetch,
    output payload_t                    dout,
    output logic                        ok
);
    localparam int PW    = $bits(payload_t);
    localparam int SHIFT = (PW == 8) ? 1 : 0;   // byte slots drop the byte bit
    localparam int SUBW  = $clog2(32 / PW);

    sdram_mux_pkg::sdram_addr_t     full, pend_addr;
    sdram_mux_pkg::sdram_rd_word_t  word;
    sdram_mux_pkg::slot0_data_t     pend_wdata;
    logic [`SDRAM_AW-2:0]           tag;
    logic [SUBW-1:0]                sub;
    logic [1:0]                     pend_mask;
    logic                           req, busy, valid, wr_done, pend_wr;
    logic                           is_wr, hit, issue;

    function automatic payload_t pick(input sdram_mux_pkg::sdram_rd_word_t w,
                                      input logic [SUBW-1:0] s);
        pick = w[s*PW +: PW];
    endfunction

    assign full  = sdram_mux_pkg::sdram_addr_t'(addr >> SHIFT) + offset;
    assign is_wr = can_write & wen;
    assign hit   = valid && (tag == full[`SDRAM_AW-1:1]);

    // payload position inside the cached word
    if (SHIFT == 1) begin : g_byte
        assign sub = {full[0], addr[0]};
    end else begin : g_half
        assign sub = full[0];
    end

    // writes always go out, reads only on a miss
    assign issue = cs && !req && !busy && !fill && (is_wr ? !wr_done : !hit);

    always_ff @(posedge clk) begin
        if (rst) begin
            req     <= 1'b0;
            busy    <= 1'b0;
            ok      <= 1'b0;
            valid   <= 1'b0;
            wr_done <= 1'b0;
        end else begin
            ok <= 1'b0;
            if (!cs || !is_wr || full != pend_addr)
                wr_done <= 1'b0;             // next write needs a new access
            if (take) begin
                req  <= 1'b0;
                busy <= 1'b1;
            end
            if (fill) begin
                busy <= 1'b0;
                if (pend_wr) begin
                    valid   <= 1'b0;         // cached word may be stale now
                    wr_done <= 1'b1;
                    ok      <= cs;
                end else begin
                    valid <= 1'b1;
                    ok    <= cs && (full[`SDRAM_AW-1:1] == pend_addr[`SDRAM_AW-1:1]);
                end
            end else if (issue) begin
                req <= 1'b1;
            end else if (cs && !req && !busy) begin
                ok <= 1'b1;                  // cache hit or finished write
            end
            if (flush)
                valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            pend_addr  <= full;
            pend_wr    <= is_wr;
            pend_wdata <= sdram_mux_pkg::slot0_data_t'(din);
            pend_mask  <= can_write ? ~wrmask : 2'b11;
        end
        if (fill && !pend_wr) begin
            word <= rd_word;
            tag  <= pend_addr[`SDRAM_AW-1:1];
        end
        dout <= pick(fill ? rd_word : word, sub);
    end

    // reads fetch the aligned pair of words
    assign fetch.req    = req;
    assign fetch.rnw    = ~pend_wr;
    assign fetch.addr   = pend_wr ? pend_addr : {pend_addr[`SDRAM_AW-1:1], 1'b0};
    assign fetch.wdata  = pend_wdata;
    assign fetch.wrmask = pend_mask;

endmodule

// ==== list.f ====
+incdir+hdl
hdl/sdram_mux_pkg.sv
hdl/slot_req.sv
hdl/offset_regs.sv
hdl/sdram_slot_arb.sv
hdl/sdram_mux_top.sv
testbench/sdram_mux_sva.sv
testbench/sdram_mux_tb.sv

// ==== testbench/sdram_mux_sva.sv ====
// protocol assertions, bound to the arbiter and to each slot requester
// unused ports are tied off at the bind
`timescale 1ns/1ps

module sdram_mux_sva (
    input logic                       clk,
    input logic                       rst,
    input logic                       rd,
    input logic                       wr,
    input sdram_mux_pkg::sdram_addr_t addr,
    input logic                       ack,
    input logic                       data_rdy,
    input logic                       wait_ack,
    input logic                       cs,
    input logic                       ok
);
    a_rd_wr_excl: assert property (@(posedge clk) disable iff (rst) !(rd && wr))
        else $error("rd and wr high together");

    // address held while the command waits for ack
    a_addr_hold: assert property (@(posedge clk) disable iff (rst)
        (rd || wr) && !ack |=> addr == $past(addr))
        else $error("command address changed before ack");

    a_rdy_after_ack: assert property (@(posedge clk) disable iff (rst)
        data_rdy |-> !wait_ack)
        else $error("data_rdy before ack");

    a_ok_needs_cs: assert property (@(posedge clk) disable iff (rst) ok |-> $past(cs))
        else $error("ok without cs");
endmodule

bind sdram_slot_arb sdram_mux_sva i_sva_arb (
    .clk(clk), .rst(rst), .rd(cmd.rd), .wr(cmd.wr), .addr(cmd.addr),
    .ack(rsp.ack), .data_rdy(rsp.data_rdy), .wait_ack(wait_ack),
    .cs(1'b0), .ok(1'b0)
);

bind slot_req sdram_mux_sva i_sva_slot (
    .clk(clk), .rst(rst), .rd(1'b0), .wr(1'b0), .addr('0),
    .ack(1'b0), .data_rdy(1'b0), .wait_ack(1'b0),
    .cs(cs), .ok(ok)
);

// ==== testbench/sdram_mux_tb.sv ====
// testbench for the two-slot SDRAM front end, with a behavioural controller
// runs a directed table followed by random rows against a reference memory
`timescale 1ns/1ps
`include "sdram_mux_consts.svh"

module sdram_mux_tb;
    typedef struct {
        string    name;
        int       slot;     // 0, 1, or 2 for both slots at once
        int       op;       // 0 read, 1 write, 2 config
        int       addr;
        int       data;     // write data, offset, or slot 1 address when slot is 2
        bit [1:0] mask;     // active high at the slot
        int       access;   // 0 none, 1 expected, 2 unchecked
    } row_t;

    logic clk, rst;
    logic [`SLOT0_AW-1:0] slot0_addr;
    logic [`SLOT1_AW-1:0] slot1_addr;
    logic slot0_cs, slot0_wen, slot1_cs, cfg_rd_sel;
    logic [1:0] slot0_wrmask;
    sdram_mux_pkg::slot0_data_t slot0_din, slot0_dout;
    sdram_mux_pkg::slot1_data_t slot1_dout;
    logic slot0_ok, slot1_ok;
    sdram_mux_pkg::cfg_wr_t cfg;
    sdram_mux_pkg::sdram_addr_t cfg_rdata, off0, off1;
    sdram_mux_pkg::sdram_rsp_t rsp = '0;
    sdram_mux_pkg::sdram_cmd_t sdram_cmd;

    logic [15:0] sdram_mem [int];    // controller storage
    logic [15:0] ref_mem [int];      // expected contents
    sdram_mux_pkg::sdram_addr_t cmd_log[$], op_addr;
    row_t rows[$];
    logic [31:0] rng = 32'd61;
    int cycles = 0, limit = 0, phase = 0, cnt = 0;
    logic op_rd;

    sdram_mux_top i_dut (
        .clk(clk), .rst(rst),
        .slot0_addr(slot0_addr), .slot0_cs(slot0_cs), .slot0_wen(slot0_wen),
        .slot0_din(slot0_din), .slot0_wrmask(slot0_wrmask),
        .slot1_addr(slot1_addr), .slot1_cs(slot1_cs),
        .cfg(cfg), .cfg_rd_sel(cfg_rd_sel), .sdram_rsp(rsp),
        .slot0_dout(slot0_dout), .slot0_ok(slot0_ok),
        .slot1_dout(slot1_dout), .slot1_ok(slot1_ok),
        .cfg_rdata(cfg_rdata), .sdram_cmd(sdram_cmd)
    );

    function logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    // power-up pattern, every address bit matters
    function logic [15:0] fill_word(input sdram_mux_pkg::sdram_addr_t a);
        return 16'(a) ^ 16'(a >> 6) ^ 16'h5a3c;
    endfunction

    function logic [15:0] sdram_rd(input sdram_mux_pkg::sdram_addr_t a);
        return sdram_mem.exists(int'(a)) ? sdram_mem[int'(a)] : fill_word(a);
    endfunction

    function logic [15:0] ref_rd(input sdram_mux_pkg::sdram_addr_t a);
        return ref_mem.exists(int'(a)) ? ref_mem[int'(a)] : fill_word(a);
    endfunction

    task automatic fail_now();
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic check_d0(input string n, input sdram_mux_pkg::slot0_data_t e,
                            input sdram_mux_pkg::slot0_data_t a);
        if (e !== a) begin
            $display("Fail %s: expected %h, actual %h", n, e, a);
            fail_now();
        end
    endtask

    task automatic check_d1(input string n, input sdram_mux_pkg::slot1_data_t e,
                            input sdram_mux_pkg::slot1_data_t a);
        if (e !== a) begin
            $display("Fail %s: expected %h, actual %h", n, e, a);
            fail_now();
        end
    endtask

    task automatic check_addr(input string n, input sdram_mux_pkg::sdram_addr_t e,
                              input sdram_mux_pkg::sdram_addr_t a);
        if (e !== a) begin
            $display("Fail %s: expected %h, actual %h", n, e, a);
            fail_now();
        end
    endtask

    task automatic check_bit(input string n, input bit e, input logic a);
        if (e !== a) begin
            $display("Fail %s: expected %b, actual %b", n, e, a);
            fail_now();
        end
    endtask

    task automatic add_row(input string n, input int slot, input int op, input int addr,
                           input int data, input bit [1:0] mask, input int access);
        row_t r;
        r.name = n;
        r.slot = slot;
        r.op = op;
        r.addr = addr;
        r.data = data;
        r.mask = mask;
        r.access = access;
        rows.push_back(r);
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles > limit) begin
            $display("timeout: test did not finish within %0d cycles", limit);
            fail_now();
        end
    end

    // controller model: ack 1..3 cycles after the command, data_rdy 2..5 after ack
    always @(posedge clk) begin
        rsp.ack <= 1'b0;
        rsp.data_rdy <= 1'b0;
        if (rst) begin
            phase <= 0;
        end else if (phase == 0) begin
            if (sdram_cmd.rd || sdram_cmd.wr) begin
                op_rd <= sdram_cmd.rd;
                op_addr <= sdram_cmd.addr;
                cmd_log.push_back(sdram_cmd.addr);
                cnt <= 1 + int'(next_rand() % 3);
                phase <= 1;
                if (sdram_cmd.wr) begin
                    logic [15:0] w;
                    w = sdram_rd(sdram_cmd.addr);
                    if (!sdram_cmd.wrmask[0]) w[7:0] = sdram_cmd.wdata[7:0];
                    if (!sdram_cmd.wrmask[1]) w[15:8] = sdram_cmd.wdata[15:8];
                    sdram_mem[int'(sdram_cmd.addr)] = w;
                end
            end
        end else if (cnt > 1) begin
            cnt <= cnt - 1;
        end else if (phase == 1) begin
            rsp.ack <= 1'b1;
            cnt <= 2 + int'(next_rand() % 4);
            phase <= 2;
        end else begin
            rsp.data_rdy <= 1'b1;
            rsp.rdata <= op_rd ? {sdram_rd(op_addr + 1), sdram_rd(op_addr)} : '0;
            phase <= 0;
        end
    end

    task automatic run_row(input row_t r);
        sdram_mux_pkg::sdram_addr_t w0, w1, exp_a;
        logic [15:0] d;
        int n0, a1;
        n0 = cmd_log.size();
        a1 = (r.slot == 2) ? r.data : r.addr;
        if (r.op == 2) begin
            @(posedge clk);
            cfg <= '{we: 1'b1, sel: r.slot[0], offset: r.data};
            @(posedge clk);
            cfg.we <= 1'b0;
            cfg_rd_sel <= r.slot[0];
            if (r.slot == 1) off1 = r.data;
            else off0 = r.data;
            @(negedge clk);
            check_addr(r.name, r.data, cfg_rdata);
            return;
        end
        w0 = off0 + sdram_mux_pkg::sdram_addr_t'(r.addr);
        w1 = off1 + sdram_mux_pkg::sdram_addr_t'(a1 >> 1);
        @(posedge clk);
        if (r.slot != 1) begin
            slot0_addr <= r.addr;
            slot0_wen <= (r.op == 1);
            slot0_din <= r.data;
            slot0_wrmask <= r.mask;
            slot0_cs <= 1'b1;
        end
        if (r.slot != 0) begin
            slot1_addr <= a1;
            slot1_cs <= 1'b1;
        end
        // hold cs until the slot answers
        do @(negedge clk);
        while (!((r.slot == 1 || slot0_ok) && (r.slot == 0 || slot1_ok)));
        if (r.op == 1) begin
            d = ref_rd(w0);
            if (r.mask[0]) d[7:0] = r.data[7:0];
            if (r.mask[1]) d[15:8] = r.data[15:8];
            ref_mem[int'(w0)] = d;
        end else begin
            if (r.slot != 1) check_d0(r.name, ref_rd(w0), slot0_dout);
            d = ref_rd(w1);
            if (r.slot != 0) check_d1(r.name, a1[0] ? d[15:8] : d[7:0], slot1_dout);
        end
        if (r.access != 2) check_bit(r.name, r.access[0], cmd_log.size() != n0);
        if (r.access == 1) begin
            exp_a = (r.slot == 1) ? w1 : w0;
            if (r.op == 0) exp_a[0] = 1'b0;    // reads fetch the even word
            check_addr(r.name, exp_a, cmd_log[n0]);
        end
        @(posedge clk);
        slot0_cs <= 1'b0;
        slot0_wen <= 1'b0;
        slot1_cs <= 1'b0;
    endtask

    initial begin
        int op;
        rst = 1'b1;
        slot0_addr = '0;
        slot0_cs = 1'b0;
        slot0_wen = 1'b0;
        slot0_din = '0;
        slot0_wrmask = 2'b00;
        slot1_addr = '0;
        slot1_cs = 1'b0;
        cfg = '0;
        cfg_rd_sel = 1'b0;
        off0 = `SLOT0_OFFSET_RST;
        off1 = `SLOT1_OFFSET_RST;

        add_row("rst_rd1", 1, 0, 'h5, 0, 2'b00, 1);
        add_row("rd1_hit", 1, 0, 'h6, 0, 2'b00, 0);
        add_row("wr_m11", 0, 1, 'h10, 'h1234, 2'b11, 1);
        add_row("rd_m11", 0, 0, 'h10, 0, 2'b00, 1);
        add_row("wr_m01", 0, 1, 'h10, 'habcd, 2'b01, 1);
        add_row("rd_m01", 0, 0, 'h10, 0, 2'b00, 1);
        add_row("wr_m10", 0, 1, 'h10, 'h5678, 2'b10, 1);
        add_row("rd_m10", 0, 0, 'h10, 0, 2'b00, 1);
        add_row("wr_m00", 0, 1, 'h10, 'hffff, 2'b00, 1);
        add_row("rd_m00", 0, 0, 'h10, 0, 2'b00, 1);
        add_row("rd0_hit", 0, 0, 'h11, 0, 2'b00, 0);
        add_row("wr_pair", 0, 1, 'h11, 'h0f0f, 2'b11, 1);
        add_row("rd_after_wr", 0, 0, 'h10, 0, 2'b00, 1);
        add_row("dual_cs", 2, 0, 'h40, 'h100, 2'b00, 1);
        // new base maps slot address 'h80 onto the word cached by dual_cs
        add_row("cfg_off1", 1, 2, 0, 'h100040, 2'b00, 0);
        add_row("rd1_newbase", 1, 0, 'h80, 0, 2'b00, 1);
        add_row("cfg_off0", 0, 2, 0, 'h200, 2'b00, 0);
        add_row("rd0_newbase", 0, 0, 'h10, 0, 2'b00, 1);
        for (int i = 0; i < 12; i++) begin
            op = int'(next_rand() % 3);
            if (op == 2)
                add_row("rand_rd1", 1, 0, int'(next_rand() % 16), 0, 2'b00, 2);
            else
                add_row(op == 1 ? "rand_wr0" : "rand_rd0", 0, op, int'(next_rand() % 8),
                        int'(next_rand() % 65536), 2'(next_rand()), 2);
        end
        limit = rows.size() * 20;

        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_bit("rst_rd", 1'b0, sdram_cmd.rd);
        check_bit("rst_wr", 1'b0, sdram_cmd.wr);
        check_bit("rst_ok0", 1'b0, slot0_ok);
        check_bit("rst_ok1", 1'b0, slot1_ok);
        foreach (rows[i])
            run_row(rows[i]);
        $display("Regression passed");
        $finish;
    end
endmodule
